/* include/umi_ep_cfg.svh */
/*
 * widths, depth and UMI opcodes for the memory endpoint
 * request opcodes have bit 0 set, response opcodes have it clear
 * size, length and burst fields of the command are not modelled
 */
`ifndef UMI_EP_CFG_SVH
`define UMI_EP_CFG_SVH

// datapath widths
`define UMI_DW 32
`define UMI_AW 4
`define UMI_CW 16

// request opcodes, low byte of the command
`define UMI_INVALID     8'h00
`define UMI_REQ_READ    8'h01
`define UMI_REQ_WRITE   8'h03
`define UMI_REQ_POSTED  8'h05
`define UMI_REQ_RDMA    8'h07
`define UMI_REQ_ATOMIC  8'h09
`define UMI_REQ_USER0   8'h0B
`define UMI_REQ_FUTURE0 8'h0D
`define UMI_REQ_LINK    8'h0F

// atomic operation, high byte of the command
`define UMI_ATOMIC_ADD  8'h00
`define UMI_ATOMIC_AND  8'h01
`define UMI_ATOMIC_OR   8'h02
`define UMI_ATOMIC_XOR  8'h03
`define UMI_ATOMIC_MAX  8'h04
`define UMI_ATOMIC_MIN  8'h05
`define UMI_ATOMIC_MAXU 8'h06
`define UMI_ATOMIC_MINU 8'h07
`define UMI_ATOMIC_SWAP 8'h08

// response opcodes
`define UMI_RESP_READ   8'h02
`define UMI_RESP_WRITE  8'h04
`define UMI_RESP_ERROR  8'h0C

`endif

/* logic/umi_ep_pkg.sv */
/*
 * shared types of the UMI memory endpoint
 * atomic enum values equal the command high byte, so a cast is enough
 */
`default_nettype none

`include "umi_ep_cfg.svh"

package umi_ep_pkg;

   // datapath words
   typedef logic [`UMI_DW-1:0] umi_data_t;
   typedef logic [`UMI_AW-1:0] umi_addr_t;
   typedef logic [`UMI_CW-1:0] umi_cmd_t;
   typedef logic [7:0]         umi_opcode_t;

   // what the endpoint does with a request
   typedef enum logic [2:0] {
      CLS_READ,
      CLS_WRITE,
      CLS_POSTED,
      CLS_ATOMIC,
      CLS_ERROR
   } umi_class_e;

   typedef enum logic [7:0] {
      AOP_ADD  = `UMI_ATOMIC_ADD,
      AOP_AND  = `UMI_ATOMIC_AND,
      AOP_OR   = `UMI_ATOMIC_OR,
      AOP_XOR  = `UMI_ATOMIC_XOR,
      AOP_MAX  = `UMI_ATOMIC_MAX,
      AOP_MIN  = `UMI_ATOMIC_MIN,
      AOP_MAXU = `UMI_ATOMIC_MAXU,
      AOP_MINU = `UMI_ATOMIC_MINU,
      AOP_SWAP = `UMI_ATOMIC_SWAP
   } umi_atomic_e;

   // exec sequencing
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_EXEC,
      ST_RESP
   } umi_exec_state_e;

endpackage

`default_nettype wire

/* logic/umi_dec_if.sv */
/*
 * decoded request handed from the decoder to the exec unit
 * valid holds from the cycle after acceptance until done pulses
 */
`timescale 1ns/10ps
`default_nettype none

interface umi_dec_if;

   logic                   valid;
   umi_ep_pkg::umi_class_e  cls;
   umi_ep_pkg::umi_atomic_e aop;
   umi_ep_pkg::umi_addr_t   addr;
   umi_ep_pkg::umi_data_t   wdata;
   // one cycle pulse when the request retires
   logic                   done;

   modport dec (
      output valid,
      output cls,
      output aop,
      output addr,
      output wdata,
      input  done
   );

   modport exec (
      input  valid,
      input  cls,
      input  aop,
      input  addr,
      input  wdata,
      output done
   );

endinterface

`default_nettype wire

/* logic/umi_cmd_decode.sv */
/*
 * request port of the endpoint, one request in flight at a time
 * unserved commands, responses and unknown atomics decode to CLS_ERROR
 * the storage read address is forwarded in the accept cycle
 */
`timescale 1ns/10ps
`default_nettype none

`include "umi_ep_cfg.svh"

module umi_cmd_decode (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  req_valid,
   output logic                  req_ready,
   input  umi_ep_pkg::umi_cmd_t  req_cmd,
   input  umi_ep_pkg::umi_addr_t req_addr,
   input  umi_ep_pkg::umi_data_t req_data,
   output umi_ep_pkg::umi_addr_t rd_addr,
   umi_dec_if.dec                dec
);

   umi_ep_pkg::umi_class_e  cls_d;
   umi_ep_pkg::umi_atomic_e aop_d;
   logic                    accept;

   assign req_ready = ~dec.valid;
   assign accept    = req_valid & req_ready;

   // keep the read port on the held address so rdata stays the old word
   assign rd_addr = dec.valid ? dec.addr : req_addr;

   // classify on the low byte
   always_comb begin
      aop_d = umi_ep_pkg::AOP_ADD;
      case (req_cmd[7:0])
         `UMI_REQ_READ:   cls_d = umi_ep_pkg::CLS_READ;
         `UMI_REQ_WRITE:  cls_d = umi_ep_pkg::CLS_WRITE;
         `UMI_REQ_POSTED: cls_d = umi_ep_pkg::CLS_POSTED;
         `UMI_REQ_ATOMIC: begin
            case (req_cmd[`UMI_CW-1:8])
               `UMI_ATOMIC_ADD, `UMI_ATOMIC_AND, `UMI_ATOMIC_OR,
               `UMI_ATOMIC_XOR, `UMI_ATOMIC_MAX, `UMI_ATOMIC_MIN,
               `UMI_ATOMIC_MAXU, `UMI_ATOMIC_MINU, `UMI_ATOMIC_SWAP: begin
                  cls_d = umi_ep_pkg::CLS_ATOMIC;
                  aop_d = umi_ep_pkg::umi_atomic_e'(req_cmd[`UMI_CW-1:8]);
               end
               default: cls_d = umi_ep_pkg::CLS_ERROR;
            endcase
         end
         // recognised but not served here
         `UMI_INVALID, `UMI_REQ_RDMA, `UMI_REQ_USER0,
         `UMI_REQ_FUTURE0, `UMI_REQ_LINK: cls_d = umi_ep_pkg::CLS_ERROR;
         default: cls_d = umi_ep_pkg::CLS_ERROR;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dec.valid <= 1'b0;
      end else if (accept) begin
         dec.valid <= 1'b1;
      end else if (dec.done) begin
         dec.valid <= 1'b0;
      end
   end

   // payload, only looked at while valid
   always_ff @(posedge clk) begin
      if (accept) begin
         dec.cls   <= cls_d;
         dec.aop   <= aop_d;
         dec.addr  <= req_addr;
         dec.wdata <= req_data;
      end
   end

endmodule

`default_nettype wire

/* logic/umi_mem_array.sv */
/*
 * word storage, one read and one write port
 * read latency is one cycle, a read beside a write returns the old word
 * no reset, contents are undefined until written
 */
`timescale 1ns/10ps
`default_nettype none

`include "umi_ep_cfg.svh"

module umi_mem_array (
   input  logic                  clk,
   input  umi_ep_pkg::umi_addr_t rd_addr,
   output umi_ep_pkg::umi_data_t rdata,
   input  logic                  we,
   input  umi_ep_pkg::umi_addr_t waddr,
   input  umi_ep_pkg::umi_data_t wdata
);

   localparam int DEPTH = 1 << `UMI_AW;

   umi_ep_pkg::umi_data_t mem [0:DEPTH-1];

   // write port
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // registered read port
   always_ff @(posedge clk) begin
      rdata <= mem[rd_addr];
   end

endmodule

`default_nettype wire

/* logic/umi_exec.sv */
/*
 * executes the decoded request against the old storage word
 * one cycle in ST_EXEC, then the response is held until accepted
 * posted writes retire straight from ST_EXEC without a response
 */
`timescale 1ns/10ps
`default_nettype none

`include "umi_ep_cfg.svh"

module umi_exec (
   input  logic                     clk,
   input  logic                     arst_n,
   umi_dec_if.exec                  dec,
   input  umi_ep_pkg::umi_data_t    rdata,
   output logic                     we,
   output umi_ep_pkg::umi_addr_t    waddr,
   output umi_ep_pkg::umi_data_t    wdata,
   output logic                     resp_valid,
   input  logic                     resp_ready,
   output umi_ep_pkg::umi_opcode_t  resp_opcode,
   output umi_ep_pkg::umi_data_t    resp_data
);

   umi_ep_pkg::umi_exec_state_e state;
   umi_ep_pkg::umi_data_t       result;
   umi_ep_pkg::umi_opcode_t     opcode_d;
   umi_ep_pkg::umi_data_t       data_d;
   logic                        is_posted;

   assign is_posted = (dec.cls == umi_ep_pkg::CLS_POSTED);

   // read-modify-write result
   always_comb begin
      case (dec.aop)
         umi_ep_pkg::AOP_ADD:  result = rdata + dec.wdata;
         umi_ep_pkg::AOP_AND:  result = rdata & dec.wdata;
         umi_ep_pkg::AOP_OR:   result = rdata | dec.wdata;
         umi_ep_pkg::AOP_XOR:  result = rdata ^ dec.wdata;
         umi_ep_pkg::AOP_MAX:
            result = ($signed(rdata) > $signed(dec.wdata)) ? rdata : dec.wdata;
         umi_ep_pkg::AOP_MIN:
            result = ($signed(rdata) < $signed(dec.wdata)) ? rdata : dec.wdata;
         umi_ep_pkg::AOP_MAXU: result = (rdata > dec.wdata) ? rdata : dec.wdata;
         umi_ep_pkg::AOP_MINU: result = (rdata < dec.wdata) ? rdata : dec.wdata;
         default:              result = dec.wdata;
      endcase
   end

   // write-back only in the exec cycle
   assign we = (state == umi_ep_pkg::ST_EXEC) &&
               ((dec.cls == umi_ep_pkg::CLS_WRITE) || is_posted ||
                (dec.cls == umi_ep_pkg::CLS_ATOMIC));
   assign waddr = dec.addr;
   assign wdata = (dec.cls == umi_ep_pkg::CLS_ATOMIC) ? result : dec.wdata;

   // response content per class
   always_comb begin
      case (dec.cls)
         umi_ep_pkg::CLS_READ, umi_ep_pkg::CLS_ATOMIC: begin
            opcode_d = `UMI_RESP_READ;
            data_d   = rdata;
         end
         umi_ep_pkg::CLS_WRITE: begin
            opcode_d = `UMI_RESP_WRITE;
            data_d   = '0;
         end
         default: begin
            opcode_d = `UMI_RESP_ERROR;
            data_d   = '0;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= umi_ep_pkg::ST_IDLE;
      end else begin
         case (state)
            umi_ep_pkg::ST_IDLE:
               if (dec.valid) state <= umi_ep_pkg::ST_EXEC;
            umi_ep_pkg::ST_EXEC:
               state <= is_posted ? umi_ep_pkg::ST_IDLE : umi_ep_pkg::ST_RESP;
            umi_ep_pkg::ST_RESP:
               if (resp_ready) state <= umi_ep_pkg::ST_IDLE;
            default:
               state <= umi_ep_pkg::ST_IDLE;
         endcase
      end
   end

   // response payload, loaded once and held under back-pressure
   always_ff @(posedge clk) begin
      if (state == umi_ep_pkg::ST_EXEC) begin
         resp_opcode <= opcode_d;
         resp_data   <= data_d;
      end
   end

   assign resp_valid = (state == umi_ep_pkg::ST_RESP);

   // retire: posted after exec, others once the response is taken
   assign dec.done = ((state == umi_ep_pkg::ST_EXEC) && is_posted) ||
                     (resp_valid && resp_ready);

endmodule

`default_nettype wire

/* logic/umi_endpoint.sv */
/*
 * UMI memory endpoint top level
 * one request in flight, a stalled response stalls the request port
 * storage is not reset, write a word before reading it
 */
`timescale 1ns/10ps
`default_nettype none

module umi_endpoint (
   input  logic                    clk,
   input  logic                    arst_n,
   // request port
   input  logic                    req_valid,
   output logic                    req_ready,
   input  umi_ep_pkg::umi_cmd_t    req_cmd,
   input  umi_ep_pkg::umi_addr_t   req_addr,
   input  umi_ep_pkg::umi_data_t   req_data,
   // response port
   output logic                    resp_valid,
   input  logic                    resp_ready,
   output umi_ep_pkg::umi_opcode_t resp_opcode,
   output umi_ep_pkg::umi_data_t   resp_data
);

   umi_ep_pkg::umi_addr_t rd_addr;
   umi_ep_pkg::umi_data_t rdata;
   logic                  we;
   umi_ep_pkg::umi_addr_t waddr;
   umi_ep_pkg::umi_data_t wdata;

   umi_dec_if dec_if ();

   umi_cmd_decode i_cmd_decode (
      .clk       (clk),
      .arst_n    (arst_n),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_cmd   (req_cmd),
      .req_addr  (req_addr),
      .req_data  (req_data),
      .rd_addr   (rd_addr),
      .dec       (dec_if.dec)
   );

   umi_mem_array i_mem_array (
      .clk     (clk),
      .rd_addr (rd_addr),
      .rdata   (rdata),
      .we      (we),
      .waddr   (waddr),
      .wdata   (wdata)
   );

   umi_exec i_exec (
      .clk         (clk),
      .arst_n      (arst_n),
      .dec         (dec_if.exec),
      .rdata       (rdata),
      .we          (we),
      .waddr       (waddr),
      .wdata       (wdata),
      .resp_valid  (resp_valid),
      .resp_ready  (resp_ready),
      .resp_opcode (resp_opcode),
      .resp_data   (resp_data)
   );

endmodule

`default_nettype wire

/* dv/umi_endpoint_properties.sv */
/*
 * port checks bound to every umi_endpoint
 * error_count holds the number of failed assertions
 */
`timescale 1ns/10ps
`default_nettype none

module umi_endpoint_properties (
   input logic                    clk,
   input logic                    arst_n,
   input logic                    req_valid,
   input logic                    req_ready,
   input logic                    resp_valid,
   input logic                    resp_ready,
   input umi_ep_pkg::umi_opcode_t resp_opcode,
   input umi_ep_pkg::umi_data_t   resp_data
);

   int error_count = 0;

   // stalled response keeps its payload
   resp_stable_a : assert property (@(posedge clk) disable iff (!arst_n)
      resp_valid && !resp_ready |=>
         resp_valid && $stable(resp_opcode) && $stable(resp_data))
   else begin
      error_count++;
      $error("response changed while stalled");
   end

   // one request in flight
   ready_after_accept_a : assert property (@(posedge clk) disable iff (!arst_n)
      req_valid && req_ready |=> !req_ready)
   else begin
      error_count++;
      $error("req_ready high right after an accept");
   end

   ready_with_resp_a : assert property (@(posedge clk) disable iff (!arst_n)
      resp_valid |-> !req_ready)
   else begin
      error_count++;
      $error("req_ready high while a response is pending");
   end

   resp_in_reset_a : assert property (@(posedge clk) !arst_n |-> !resp_valid)
   else begin
      error_count++;
      $error("resp_valid high during reset");
   end

   resp_after_reset_a : assert property (@(posedge clk) $rose(arst_n) |-> !resp_valid)
   else begin
      error_count++;
      $error("resp_valid high in the first cycle after reset");
   end

endmodule

bind umi_endpoint umi_endpoint_properties i_props (
   .clk         (clk),
   .arst_n      (arst_n),
   .req_valid   (req_valid),
   .req_ready   (req_ready),
   .resp_valid  (resp_valid),
   .resp_ready  (resp_ready),
   .resp_opcode (resp_opcode),
   .resp_data   (resp_data)
);

`default_nettype wire

/* dv/umi_endpoint_tb.sv */
/*
 * testbench for the UMI memory endpoint
 * requests and expected responses come from dv/umi_stimulus.txt
 * run from the project root so that the stimulus path resolves
 * resp_ready is withheld at random from a fixed seed
 */
`timescale 1ns/10ps
`default_nettype none

module umi_endpoint_tb;

   localparam int CLK_PERIOD = 40;
   localparam int DRIVE_DLY  = 2;
   localparam int TIMEOUT    = 64;

   logic                    clk;
   logic                    arst_n;
   logic                    req_valid;
   logic                    req_ready;
   umi_ep_pkg::umi_cmd_t    req_cmd;
   umi_ep_pkg::umi_addr_t   req_addr;
   umi_ep_pkg::umi_data_t   req_data;
   logic                    resp_valid;
   logic                    resp_ready;
   umi_ep_pkg::umi_opcode_t resp_opcode;
   umi_ep_pkg::umi_data_t   resp_data;

   int seed;
   int n_requests;

   umi_endpoint i_dut (
      .clk         (clk),
      .arst_n      (arst_n),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .req_cmd     (req_cmd),
      .req_addr    (req_addr),
      .req_data    (req_data),
      .resp_valid  (resp_valid),
      .resp_ready  (resp_ready),
      .resp_opcode (resp_opcode),
      .resp_data   (resp_data)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic end_with_failure();
      $display("Verification failed");
      $fatal(1);
   endtask

   // a failed bound assertion ends the run at once
   always @(negedge clk) begin
      if (i_dut.i_props.error_count != 0) begin
         $display("bound assertion failed before %0t ns", $time);
         end_with_failure();
      end
   end

   // inputs change a little after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   task automatic check_opcode(input string name, input umi_ep_pkg::umi_opcode_t exp,
                               input umi_ep_pkg::umi_opcode_t act);
      if (act !== exp) begin
         $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
         end_with_failure();
      end
   endtask

   task automatic check_data(input string name, input umi_ep_pkg::umi_data_t exp,
                             input umi_ep_pkg::umi_data_t act);
      if (act !== exp) begin
         $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
         end_with_failure();
      end
   endtask

   // ready is stable between edges, so sampling here shows the next edge
   task automatic wait_accept();
      int   cycles;
      logic taken;
      cycles = 0;
      taken  = 1'b0;
      while (!taken) begin
         if (cycles == TIMEOUT) begin
            $display("timeout: request not accepted within %0d cycles", TIMEOUT);
            end_with_failure();
         end
         taken = req_ready;
         next_cycle();
         cycles++;
      end
   endtask

   task automatic wait_response(input umi_ep_pkg::umi_opcode_t exp_op,
                                input umi_ep_pkg::umi_data_t   exp_data);
      int                      cycles;
      logic                    taken;
      logic                    seen;
      logic [31:0]             rnd;
      umi_ep_pkg::umi_opcode_t held_op;
      umi_ep_pkg::umi_data_t   held_data;
      cycles    = 0;
      taken     = 1'b0;
      seen      = 1'b0;
      held_op   = '0;
      held_data = '0;
      while (!taken) begin
         if (cycles == TIMEOUT) begin
            $display("timeout: no response taken within %0d cycles", TIMEOUT);
            end_with_failure();
         end
         if (req_ready) begin
            $display("req_ready went high before the response was taken");
            end_with_failure();
         end
         rnd        = $random(seed);
         resp_ready = rnd[0];
         if (resp_valid) begin
            // a stalled response must not move
            if (seen) begin
               check_opcode("resp_opcode", held_op, resp_opcode);
               check_data("resp_data", held_data, resp_data);
            end
            seen      = 1'b1;
            held_op   = resp_opcode;
            held_data = resp_data;
            taken     = resp_ready;
         end
         next_cycle();
         cycles++;
      end
      check_opcode("resp_opcode", exp_op, held_op);
      check_data("resp_data", exp_data, held_data);
   endtask

   // no response may show up until the request port opens again
   task automatic wait_retire();
      int   cycles;
      logic done;
      cycles = 0;
      done   = 1'b0;
      while (!done) begin
         if (resp_valid) begin
            $display("unexpected response at %0t ns", $time);
            end_with_failure();
         end
         if (req_ready) begin
            done = 1'b1;
         end else begin
            if (cycles == TIMEOUT) begin
               $display("timeout: request did not retire within %0d cycles", TIMEOUT);
               end_with_failure();
            end
            next_cycle();
            cycles++;
         end
      end
   endtask

   task automatic run_request(input umi_ep_pkg::umi_cmd_t    cmd,
                              input umi_ep_pkg::umi_addr_t   addr,
                              input umi_ep_pkg::umi_data_t   data,
                              input logic                    has_resp,
                              input umi_ep_pkg::umi_opcode_t exp_op,
                              input umi_ep_pkg::umi_data_t   exp_data);
      req_valid = 1'b1;
      req_cmd   = cmd;
      req_addr  = addr;
      req_data  = data;
      wait_accept();
      // request inputs are free to change once the request is taken
      req_valid = 1'b0;
      req_cmd   = ~cmd;
      req_addr  = ~addr;
      req_data  = ~data;
      if (has_resp) begin
         wait_response(exp_op, exp_data);
      end
      wait_retire();
   endtask

   initial begin : main
      int                      fd;
      int                      code;
      string                   line;
      umi_ep_pkg::umi_cmd_t    cmd;
      umi_ep_pkg::umi_addr_t   addr;
      umi_ep_pkg::umi_data_t   data;
      logic                    has_resp;
      umi_ep_pkg::umi_opcode_t exp_op;
      umi_ep_pkg::umi_data_t   exp_data;

      seed       = 32'hf074_b7e8;
      n_requests = 0;
      clk        = 1'b0;
      arst_n     = 1'b0;
      req_valid  = 1'b0;
      req_cmd    = '0;
      req_addr   = '0;
      req_data   = '0;
      resp_ready = 1'b0;

      repeat (2) @(posedge clk);
      #DRIVE_DLY;
      arst_n = 1'b1;
      if (!req_ready || resp_valid) begin
         $display("request and response ports not idle after reset");
         end_with_failure();
      end

      fd = $fopen("dv/umi_stimulus.txt", "r");
      if (fd == 0) begin
         $display("cannot open dv/umi_stimulus.txt");
         end_with_failure();
      end
      while (!$feof(fd)) begin
         line = "";
         code = $fgets(line, fd);
         code = $sscanf(line, "%h %h %h %h %h %h",
                        cmd, addr, data, has_resp, exp_op, exp_data);
         if (code == 6) begin
            run_request(cmd, addr, data, has_resp, exp_op, exp_data);
            n_requests++;
         end else if (code > 0) begin
            $display("malformed stimulus line: %s", line);
            end_with_failure();
         end
      end
      $fclose(fd);
      if (n_requests == 0) begin
         $display("stimulus file holds no requests");
         end_with_failure();
      end

      // quiet tail with nothing left to answer
      resp_ready = 1'b1;
      repeat (8) begin
         if (resp_valid) begin
            $display("extra response after the last request");
            end_with_failure();
         end
         next_cycle();
      end

      if (i_dut.i_props.error_count != 0) begin
         $display("%0d bound assertion failures", i_dut.i_props.error_count);
         end_with_failure();
      end else begin
         $display("Verification passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
logic/umi_ep_pkg.sv
logic/umi_dec_if.sv
logic/umi_cmd_decode.sv
logic/umi_mem_array.sv
logic/umi_exec.sv
logic/umi_endpoint.sv
dv/umi_endpoint_properties.sv
dv/umi_endpoint_tb.sv

/* Makefile */
# Verilator build and run of the UMI memory endpoint testbench
# run from the project root, the testbench opens dv/umi_stimulus.txt

VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := umi_endpoint_tb
RTL_TOP   := umi_endpoint
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_LOG   := sim.log
SIM_ARGS  := +verilator+error+limit+100
SOURCES   := $(wildcard include/*.svh logic/*.sv dv/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(SIM_LOG)
	grep -q "^Verification passed" $(SIM_LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

/* dv/umi_stimulus.txt */
# columns in hex: cmd addr data resp_expected resp_opcode resp_data
# cmd high byte is the atomic operation, low byte the request opcode
0003 0 12345678 1 04 00000000
0003 1 a5a5a5a5 1 04 00000000
0001 0 00000000 1 02 12345678
0001 1 00000000 1 02 a5a5a5a5
0005 2 cafef00d 0 00 00000000
0001 2 00000000 1 02 cafef00d
0003 3 fffffffe 1 04 00000000
0009 3 00000005 1 02 fffffffe
0109 3 00000001 1 02 00000003
0209 3 80000000 1 02 00000001
0309 3 ffffffff 1 02 80000001
0409 3 80000000 1 02 7ffffffe
0609 3 80000000 1 02 7ffffffe
0509 3 00000005 1 02 80000000
0709 3 00000005 1 02 80000000
0809 3 deadbeef 1 02 00000005
0001 3 00000000 1 02 deadbeef
0000 0 ffffffff 1 0c 00000000
0007 0 ffffffff 1 0c 00000000
000b 0 ffffffff 1 0c 00000000
000d 0 ffffffff 1 0c 00000000
000f 0 ffffffff 1 0c 00000000
0909 0 ffffffff 1 0c 00000000
0001 0 00000000 1 02 12345678
